//--- design/board_store.sv
// stores rows 1..15; row 0 is an implicit full ground
// place, clear_row and wipe are exclusive strobes, each lands at the next edge
// cells of a piece above row 15 are lost
`timescale 1ns/1ns

module board_store (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 place_i,
	input  logic                 clear_row_i,
	input  logic                 wipe_i,
	input  tetris_pkg::mask_t    mask_i,
	input  logic [2:0]           position_i,
	input  tetris_pkg::row_t     land_row_i,
	output tetris_pkg::grid_t    grid_o,
	output logic                 row_full_any_o,
	output logic                 ceiling_hit_o
);

	tetris_pkg::grid_t grid_q;
	tetris_pkg::grid_t grid_put;   // board with the piece ORed in
	tetris_pkg::grid_t grid_clr;   // board with the lowest full row removed
	tetris_pkg::row_t  low_full;
	logic [tetris_pkg::FIELD_H-1:0] full_vec;

	// ------------------------------
	// row flags
	// ------------------------------
	always_comb begin
		for (int r = 1; r <= tetris_pkg::FIELD_H; r++) begin
			full_vec[r-1] = &tetris_pkg::grid_row(grid_q, r);
		end
		low_full = '0;
		for (int r = tetris_pkg::FIELD_H; r >= 1; r--) begin
			if (full_vec[r-1]) begin
				low_full = tetris_pkg::row_t'(r);
			end
		end
	end

	assign row_full_any_o = |full_vec;
	assign ceiling_hit_o  = |tetris_pkg::grid_row(grid_q, tetris_pkg::FIELD_H + 1); // row 13

	// ------------------------------
	// next board candidates
	// ------------------------------
	always_comb begin
		int row;
		grid_put = grid_q;
		for (int r = 0; r < 4; r++) begin
			row = int'(land_row_i) + r;
			if (row >= 1 && row <= tetris_pkg::GRID_ROWS) begin
				grid_put[(row-1)*tetris_pkg::FIELD_W +: tetris_pkg::FIELD_W] =
					grid_put[(row-1)*tetris_pkg::FIELD_W +: tetris_pkg::FIELD_W] |
					tetris_pkg::place_row(mask_i, r, position_i);
			end
		end
	end

	// rows from low_full upwards take the row above them
	always_comb begin
		grid_clr = grid_q;
		for (int r = 1; r < tetris_pkg::GRID_ROWS; r++) begin
			if (tetris_pkg::row_t'(r) >= low_full) begin
				grid_clr[(r-1)*tetris_pkg::FIELD_W +: tetris_pkg::FIELD_W] =
					tetris_pkg::grid_row(grid_q, r + 1);
			end
		end
		grid_clr[(tetris_pkg::GRID_ROWS-1)*tetris_pkg::FIELD_W +: tetris_pkg::FIELD_W] = '0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grid_q <= '0;
		end else if (wipe_i) begin
			grid_q <= '0;
		end else if (place_i) begin
			grid_q <= grid_put;
		end else if (clear_row_i) begin
			grid_q <= grid_clr;  // one row per cycle
		end
	end

	assign grid_o = grid_q;

endmodule

//--- design/drop_finder.sv
// combinational landing search, valid whenever grid_i and mask_i are stable
// rows above the stored grid count as empty
`timescale 1ns/1ns

module drop_finder (
	input  tetris_pkg::grid_t grid_i,
	input  tetris_pkg::mask_t mask_i,
	input  logic [2:0]        position_i,
	output tetris_pkg::row_t  land_row_o
);

	// hit[b] set when the piece base at row b collides, b = 0 is the ground
	logic [tetris_pkg::GRID_ROWS-1:0] hit;

	always_comb begin
		for (int b = 0; b < tetris_pkg::GRID_ROWS; b++) begin
			hit[b] = 1'b0;
			for (int r = 0; r < 4; r++) begin
				hit[b] = hit[b] |
					(|(tetris_pkg::place_row(mask_i, r, position_i) &
					   tetris_pkg::grid_row(grid_i, b + r)));
			end
		end
	end

	// ------------------------------
	// highest collision wins
	// ------------------------------
	// the piece falls from above, so it stops one row over the first
	// collision met on the way down
	always_comb begin
		land_row_o = '0;
		for (int b = 0; b < tetris_pkg::GRID_ROWS; b++) begin
			if (hit[b]) begin
				land_row_o = tetris_pkg::row_t'(b + 1);
			end
		end
	end

endmodule

//--- design/game_ctrl.sv
// in_valid_i is only taken in idle; a strobe during a piece is dropped
// score wraps at 16 points
`timescale 1ns/1ns

module game_ctrl (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           in_valid_i,
	input  tetris_pkg::shape_e             shape_i,
	input  logic [2:0]                     position_i,
	input  logic                           row_full_any_i,
	input  logic                           ceiling_hit_i,
	output tetris_pkg::shape_e             piece_shape_o,
	output logic [2:0]                     piece_pos_o,
	output logic                           place_o,
	output logic                           clear_row_o,
	output logic                           wipe_o,
	output logic                           score_valid_o,
	output logic                           tetris_valid_o,
	output logic                           fail_o,
	output logic [tetris_pkg::SCORE_W-1:0] score_o
);

	tetris_pkg::state_e state_q;
	tetris_pkg::state_e state_d;
	tetris_pkg::shape_e shape_q;
	logic [2:0]                                     pos_q;
	logic [tetris_pkg::SCORE_W-1:0]                 score_q;
	logic [$clog2(tetris_pkg::PIECES_PER_GAME)-1:0] piece_cnt_q;
	logic                                           game_end;

	// ------------------------------
	// FSM
	// ------------------------------
	always_comb begin
		case (state_q)
			tetris_pkg::ST_IDLE:   state_d = in_valid_i ? tetris_pkg::ST_DROP : tetris_pkg::ST_IDLE;
			tetris_pkg::ST_DROP:   state_d = tetris_pkg::ST_CLEAR;
			tetris_pkg::ST_CLEAR:  state_d = row_full_any_i ? tetris_pkg::ST_CLEAR
			                                                : tetris_pkg::ST_REPORT;
			tetris_pkg::ST_REPORT: state_d = tetris_pkg::ST_IDLE;
			default:               state_d = tetris_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= tetris_pkg::ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// piece registers
	always_ff @(posedge clk) begin
		if (in_valid_i && state_q == tetris_pkg::ST_IDLE) begin
			shape_q <= shape_i;
			pos_q   <= position_i;
		end
	end

	// 16th piece or anything left in row 13
	assign game_end = (state_q == tetris_pkg::ST_REPORT) &&
	                  (ceiling_hit_i ||
	                   int'(piece_cnt_q) == tetris_pkg::PIECES_PER_GAME - 1);

	// ------------------------------
	// score and piece count
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			score_q <= '0;
		end else if (clear_row_o) begin
			score_q <= score_q + 1'b1;
		end else if (game_end) begin
			score_q <= '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			piece_cnt_q <= '0;
		end else if (game_end) begin
			piece_cnt_q <= '0;
		end else if (state_q == tetris_pkg::ST_REPORT) begin
			piece_cnt_q <= piece_cnt_q + 1'b1;
		end
	end

	assign piece_shape_o  = shape_q;
	assign piece_pos_o    = pos_q;
	assign place_o        = (state_q == tetris_pkg::ST_DROP);
	assign clear_row_o    = (state_q == tetris_pkg::ST_CLEAR) && row_full_any_i;
	assign wipe_o         = game_end;   // board cleared at the edge after the dump
	assign score_valid_o  = (state_q == tetris_pkg::ST_REPORT);
	assign tetris_valid_o = game_end;
	assign fail_o         = score_valid_o && ceiling_hit_i;
	assign score_o        = score_valid_o ? score_q : '0;

endmodule

//--- design/shape_rom.sv
// purely combinational, one fixed orientation per shape code
`timescale 1ns/1ns

module shape_rom (
	input  tetris_pkg::shape_e shape_i,
	output tetris_pkg::mask_t  mask_o
);

	// nibbles top row first; col 0 is the lsb so the pictures read mirrored
	always_comb begin
		case (shape_i)
			tetris_pkg::SHAPE_SQUARE: begin
				mask_o = {4'b0000, 4'b0000, 4'b0011, 4'b0011};
			end
			tetris_pkg::SHAPE_LINE_V: begin
				mask_o = {4'b0001, 4'b0001, 4'b0001, 4'b0001};
			end
			tetris_pkg::SHAPE_LINE_H: begin
				mask_o = {4'b0000, 4'b0000, 4'b0000, 4'b1111};
			end
			tetris_pkg::SHAPE_L_INV: begin
				// hook at top left
				mask_o = {4'b0000, 4'b0011, 4'b0010, 4'b0010};
			end
			tetris_pkg::SHAPE_L_HORI: begin
				mask_o = {4'b0000, 4'b0000, 4'b0111, 4'b0001};
			end
			tetris_pkg::SHAPE_L_NORM: begin
				mask_o = {4'b0000, 4'b0001, 4'b0001, 4'b0011};
			end
			tetris_pkg::SHAPE_S_VERT: begin
				mask_o = {4'b0000, 4'b0001, 4'b0011, 4'b0010};
			end
			tetris_pkg::SHAPE_S_NORM: begin
				mask_o = {4'b0000, 4'b0000, 4'b0110, 4'b0011};
			end
			default: begin
				mask_o = '0;  // unknown code places nothing
			end
		endcase
	end

endmodule

//--- design/tetris_pkg.sv
// field geometry is fixed here; no module takes geometry parameters
// pieces must stay inside columns 0..5, a wider placement is undefined
package tetris_pkg;

	// ------------------------------
	// geometry and game limits
	// ------------------------------
	localparam int FIELD_W         = 6;   // columns
	localparam int FIELD_H         = 12;  // visible rows
	localparam int CEIL_ROWS       = 3;   // hidden rows above the field
	localparam int GRID_ROWS       = FIELD_H + CEIL_ROWS; // stored rows 1..15
	localparam int PIECES_PER_GAME = 16;
	localparam int SCORE_W         = 4;

	// ------------------------------
	// types
	// ------------------------------
	typedef enum logic [2:0] {
		SHAPE_SQUARE,
		SHAPE_LINE_V,
		SHAPE_LINE_H,
		SHAPE_L_INV,
		SHAPE_L_HORI,
		SHAPE_L_NORM,
		SHAPE_S_VERT,
		SHAPE_S_NORM
	} shape_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DROP,
		ST_CLEAR,
		ST_REPORT
	} state_e;

	typedef logic [15:0]                  mask_t;  // bit row*4+col, row 0 at bottom
	typedef logic [GRID_ROWS*FIELD_W-1:0] grid_t;  // bit (row-1)*6+col
	typedef logic [3:0]                   row_t;

	// one piece row shifted to its columns
	function automatic logic [FIELD_W-1:0] place_row(mask_t mask, int r, logic [2:0] pos);
		logic [FIELD_W+2:0] wide;
		wide = '0;
		wide[3:0] = mask[r*4 +: 4];
		wide = wide << pos;  // bits past column 5 fall off
		return wide[FIELD_W-1:0];
	endfunction

	// board row with the implicit ground at row 0
	function automatic logic [FIELD_W-1:0] grid_row(grid_t grid, int r);
		if (r == 0)
			return '1;
		if (r > GRID_ROWS)
			return '0;
		return grid[(r-1)*FIELD_W +: FIELD_W];
	endfunction

endpackage

//--- design/tetris_top.sv
// one piece per in_valid_i strobe, no back-pressure
// wait for score_valid_o before the next strobe
`timescale 1ns/1ns

module tetris_top (
	input  logic                                           clk,
	input  logic                                           rst_n,
	input  logic                                           in_valid_i,
	input  tetris_pkg::shape_e                             shape_i,
	input  logic [2:0]                                     position_i,
	output logic                                           score_valid_o,
	output logic                                           tetris_valid_o,
	output logic                                           fail_o,
	output logic [tetris_pkg::SCORE_W-1:0]                 score_o,
	output logic [tetris_pkg::FIELD_H*tetris_pkg::FIELD_W-1:0] tetris_o
);

	tetris_pkg::shape_e piece_shape;
	logic [2:0]         piece_pos;
	tetris_pkg::mask_t  piece_mask;
	tetris_pkg::row_t   land_row;
	tetris_pkg::grid_t  grid;
	logic               place;
	logic               clear_row;
	logic               wipe;
	logic               row_full_any;
	logic               ceiling_hit;

	game_ctrl i_game_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid_i     (in_valid_i),
		.shape_i        (shape_i),
		.position_i     (position_i),
		.row_full_any_i (row_full_any),
		.ceiling_hit_i  (ceiling_hit),
		.piece_shape_o  (piece_shape),
		.piece_pos_o    (piece_pos),
		.place_o        (place),
		.clear_row_o    (clear_row),
		.wipe_o         (wipe),
		.score_valid_o  (score_valid_o),
		.tetris_valid_o (tetris_valid_o),
		.fail_o         (fail_o),
		.score_o        (score_o)
	);

	shape_rom i_shape_rom (
		.shape_i (piece_shape),
		.mask_o  (piece_mask)
	);

	drop_finder i_drop_finder (
		.grid_i     (grid),
		.mask_i     (piece_mask),
		.position_i (piece_pos),
		.land_row_o (land_row)
	);

	board_store i_board_store (
		.clk            (clk),
		.rst_n          (rst_n),
		.place_i        (place),
		.clear_row_i    (clear_row),
		.wipe_i         (wipe),
		.mask_i         (piece_mask),
		.position_i     (piece_pos),
		.land_row_i     (land_row),
		.grid_o         (grid),
		.row_full_any_o (row_full_any),
		.ceiling_hit_o  (ceiling_hit)
	);

	// visible rows only, zero outside the dump cycle
	assign tetris_o = tetris_valid_o ?
	                  grid[tetris_pkg::FIELD_H*tetris_pkg::FIELD_W-1:0] : '0;

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_tetris -f vlog.f -o tb_tetris
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_tetris > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	echo "testbench reported failure"
	exit 1
fi

exit 0

//--- testbench/tb_tetris.sv
// each test starts from a reset; a game left open is played out with vertical lines
// so that its board shows up in a dump. positions must keep pieces inside the field
`timescale 1ns/1ns

module tb_tetris;

	localparam int N_TESTS     = 13;
	localparam int N_PIECES    = 37;
	localparam int N_RANDOM    = 20;
	// table and random pieces plus one played-out game per test
	localparam int CYCLE_LIMIT = 40 * (N_PIECES + N_RANDOM) + (N_TESTS + 1) * (16 * 40 + 20);

	logic               clk;
	logic               rst_n;
	logic               in_valid_i;
	tetris_pkg::shape_e shape_i;
	logic [2:0]         position_i;
	logic               score_valid_o;
	logic               tetris_valid_o;
	logic               fail_o;
	logic [3:0]         score_o;
	logic [71:0]        tetris_o;

	// ------------------------------
	// stimulus table
	// ------------------------------
	// name, pieces, score after the last piece, fails among the listed pieces
	string t_name [N_TESTS] = '{
		"alone_square", "alone_line_v", "alone_line_h", "alone_l_inv",
		"alone_l_hori", "alone_l_norm", "alone_s_vert", "alone_s_norm",
		"stack_s_on_square", "row_clear", "double_clear", "ceiling_fail", "full_game"};
	int t_len   [N_TESTS] = '{1, 1, 1, 1, 1, 1, 1, 1, 2, 3, 3, 5, 16};
	int t_score [N_TESTS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 2, 0, 10};
	int t_fails [N_TESTS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0};

	// upper digit shape code, lower digit left column
	logic [7:0] piece_tab [N_PIECES] = '{
		8'h02, 8'h15, 8'h21, 8'h34, 8'h43, 8'h50, 8'h62, 8'h73,
		8'h00, 8'h70,
		8'h04, 8'h20, 8'h50,
		8'h20, 8'h20, 8'h04,
		8'h10, 8'h10, 8'h10, 8'h10, 8'h02,
		8'h20, 8'h04, 8'h20, 8'h20, 8'h04, 8'h20, 8'h20, 8'h04, 8'h20,
		8'h20, 8'h04, 8'h20, 8'h20, 8'h04, 8'h20, 8'h20};

	// four row and col pairs per shape with row 0 at the bottom
	int shape_cells [8][8] = '{
		'{0, 0, 0, 1, 1, 0, 1, 1},  // square
		'{0, 0, 1, 0, 2, 0, 3, 0},  // vertical line
		'{0, 0, 0, 1, 0, 2, 0, 3},  // horizontal line
		'{0, 1, 1, 1, 2, 0, 2, 1},  // inverted L
		'{0, 0, 1, 0, 1, 1, 1, 2},  // horizontal L
		'{0, 0, 0, 1, 1, 0, 2, 0},  // upright L
		'{0, 1, 1, 0, 1, 1, 2, 0},  // vertical S
		'{0, 0, 0, 1, 1, 1, 1, 2}}; // flat S

	logic [5:0] m_board [1:15];
	logic [3:0] m_score;
	logic [3:0] last_score;
	int         m_count;
	int         m_rows;
	bit         m_fail;
	bit         m_end;
	bit         last_end;
	bit         run_over;
	int         seed;
	int         cycles;
	int         errors;
	int         test_errs;
	int         tests_run;
	int         tests_failed;
	int         fail_cnt;

	tetris_top i_tetris_top (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid_i     (in_valid_i),
		.shape_i        (shape_i),
		.position_i     (position_i),
		.score_valid_o  (score_valid_o),
		.tetris_valid_o (tetris_valid_o),
		.fail_o         (fail_o),
		.score_o        (score_o),
		.tetris_o       (tetris_o)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// ------------------------------
	// board model
	// ------------------------------
	function automatic bit collides(input int shp, input int pos, input int base);
		int r;
		int c;
		for (int i = 0; i < 4; i++) begin
			r = base + shape_cells[shp][2*i];
			c = pos + shape_cells[shp][2*i+1];
			if (r <= 0) begin
				return 1'b1;  // ground
			end
			if (r <= 15 && m_board[r][c]) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	function automatic int lowest_full();
		for (int r = 1; r <= 12; r++) begin
			if (&m_board[r]) begin
				return r;
			end
		end
		return 0;
	endfunction

	function automatic logic [71:0] board_dump();
		logic [71:0] d;
		for (int r = 1; r <= 12; r++) begin
			d[(r-1)*6 +: 6] = m_board[r];
		end
		return d;
	endfunction

	function automatic int max_pos(input int shp);
		int w;
		w = 0;
		for (int i = 0; i < 4; i++) begin
			if (shape_cells[shp][2*i+1] + 1 > w) begin
				w = shape_cells[shp][2*i+1] + 1;
			end
		end
		return 6 - w;
	endfunction

	task model_clear();
		for (int r = 1; r <= 15; r++) begin
			m_board[r] = '0;
		end
		m_score = '0;
		m_count = 0;
		m_fail  = 1'b0;
		m_end   = 1'b0;
	endtask

	task model_drop(input int shp, input int pos);
		int base;
		int r;
		int low;
		base = 15;
		while (!collides(shp, pos, base - 1)) begin
			base--;  // falls from the top
		end
		for (int i = 0; i < 4; i++) begin
			r = base + shape_cells[shp][2*i];
			if (r <= 15) begin
				m_board[r][pos + shape_cells[shp][2*i+1]] = 1'b1;
			end
		end
		m_rows = 0;
		low = lowest_full();
		while (low != 0) begin
			for (int k = low; k < 15; k++) begin
				m_board[k] = m_board[k+1];
			end
			m_board[15] = '0;
			m_score = m_score + 4'd1;
			m_rows++;
			low = lowest_full();
		end
		m_count++;
		m_fail = |m_board[13];
		m_end  = m_fail || m_count == 16;
	endtask

	// ------------------------------
	// stimulus and checks
	// ------------------------------
	task report_err(input string tname, input string what, input logic [71:0] exp,
	                input logic [71:0] act);
		$display("ERR %0s %0s expected %0h actual %0h", tname, what, exp, act);
		test_errs++;
		errors++;
	endtask

	task reset_dut();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task run_piece(input string tname, input int shp, input int pos);
		logic [71:0] exp_dump;
		int          lat;
		model_drop(shp, pos);
		exp_dump = m_end ? board_dump() : '0;
		@(posedge clk);
		in_valid_i <= 1'b1;
		shape_i    <= tetris_pkg::shape_e'(3'(shp));
		position_i <= 3'(pos);
		@(posedge clk);
		in_valid_i <= 1'b0;
		lat = 0;
		@(negedge clk);
		while (!score_valid_o) begin
			if (tetris_o !== '0) begin
				report_err(tname, "board outside dump", '0, tetris_o);
			end
			@(negedge clk);
			lat++;
		end
		// place edge, one clear edge per removed row plus one, then report
		if (lat != 2 + m_rows) begin
			report_err(tname, "latency", 2 + m_rows, lat);
		end
		if (score_o !== m_score) begin
			report_err(tname, "score", m_score, score_o);
		end
		if (fail_o !== m_fail) begin
			report_err(tname, "fail", m_fail, fail_o);
		end
		if (tetris_valid_o !== m_end) begin
			report_err(tname, "tetris_valid", m_end, tetris_valid_o);
		end
		if (tetris_o !== exp_dump) begin
			report_err(tname, "board", exp_dump, tetris_o);
		end
		last_score = score_o;
		last_end   = m_end;
		if (fail_o) begin
			fail_cnt++;
		end
		if (m_end) begin
			model_clear();  // DUT wipes at the next edge
		end
	endtask

	task start_test();
		reset_dut();
		model_clear();
		test_errs = 0;
		fail_cnt  = 0;
		last_end  = 1'b0;
	endtask

	task flush_game(input string tname);
		while (!last_end) begin
			run_piece(tname, 1, 5);
		end
	endtask

	task finish_test(input string tname, input int n);
		$display("%0s: %0d pieces, %0d errors", tname, n, test_errs);
		tests_run++;
		if (test_errs != 0) begin
			tests_failed++;
		end
	endtask

	initial begin : watchdog
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		run_over = 1'b1;
		$display("timeout: no end of the test sequence after %0d cycles", cycles);
		$display("Simulation failed");
		$finish;
	end

	initial begin : main
		int p;
		int shp;
		int pos;
		rst_n        = 1'b0;
		in_valid_i   = 1'b0;
		shape_i      = tetris_pkg::SHAPE_SQUARE;
		position_i   = '0;
		seed         = 32'h91e9;
		run_over     = 1'b0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		p = 0;
		for (int t = 0; t < N_TESTS; t++) begin
			start_test();
			for (int k = 0; k < t_len[t]; k++) begin
				run_piece(t_name[t], int'(piece_tab[p][7:4]), int'(piece_tab[p][3:0]));
				p++;
			end
			if (last_score != t_score[t]) begin
				report_err(t_name[t], "final score", t_score[t], last_score);
			end
			if (fail_cnt != t_fails[t]) begin
				report_err(t_name[t], "fail count", t_fails[t], fail_cnt);
			end
			flush_game(t_name[t]);
			finish_test(t_name[t], t_len[t]);
		end
		start_test();
		for (int k = 0; k < N_RANDOM; k++) begin
			shp = $unsigned($random(seed)) % 8;
			pos = $unsigned($random(seed)) % (max_pos(shp) + 1);
			run_piece("random_mix", shp, pos);
		end
		flush_game("random_mix");
		finish_test("random_mix", N_RANDOM);
		run_over = 1'b1;
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// stopped before the end of the sequence
	final begin
		if (!run_over) begin
			$display("Simulation failed");
		end
	end

endmodule

//--- testbench/tetris_assert.sv
// protocol checks on the output strobes of tetris_top
`timescale 1ns/1ns

module tetris_assert (
	input logic                           clk,
	input logic                           rst_n,
	input logic                           score_valid_i,
	input logic                           tetris_valid_i,
	input logic                           fail_i,
	input logic [tetris_pkg::SCORE_W-1:0] score_i
);

	fail_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
		fail_i |-> score_valid_i)
		else $error("fail_o high without score_valid_o");

	dump_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
		tetris_valid_i |-> score_valid_i)
		else $error("tetris_valid_o high without score_valid_o");

	valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		score_valid_i |=> !score_valid_i)
		else $error("score_valid_o held for two cycles");

	score_zero_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!score_valid_i |-> score_i == '0)
		else $error("score_o nonzero outside score_valid_o");

endmodule

bind tetris_top tetris_assert i_tetris_assert (
	.clk            (clk),
	.rst_n          (rst_n),
	.score_valid_i  (score_valid_o),
	.tetris_valid_i (tetris_valid_o),
	.fail_i         (fail_o),
	.score_i        (score_o)
);

//--- vlog.f
design/tetris_pkg.sv
design/shape_rom.sv
design/drop_finder.sv
design/board_store.sv
design/game_ctrl.sv
design/tetris_top.sv
testbench/tetris_assert.sv
testbench/tb_tetris.sv
